/* compile.f */
+incdir+design
design/loader_pkg.sv
design/byte_assembler.sv
design/word_router.sv
design/line_writer.sv
design/program_loader.sv
dv/program_loader_tb.sv

/* design/byte_assembler.sv */
`timescale 1ns/100ps
`default_nettype none
`include "loader_settings.svh"

module byte_assembler (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [7:0]            rx_data,
    input  logic                  rx_valid,
    output logic                  rx_ready,
    output loader_pkg::asm_word_t word,
    input  logic                  word_ready,
    input  logic                  stop
);

    localparam int WB    = `LD_WORD_BITS;
    localparam int BYTES = WB / 8;
    localparam int IW    = $clog2(BYTES);

    logic [IW-1:0]   idx;     // byte position within the word
    logic [WB-9:0]   shift;   // bytes already received, byte 0 lowest
    logic            rx_take;

    // no new byte while a word waits downstream
    assign rx_ready = !word.valid && !stop;
    assign rx_take  = rx_valid && rx_ready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            idx        <= '0;
            word.valid <= 1'b0;
        end else begin
            if (word.valid && word_ready) begin
                word.valid <= 1'b0;
            end
            if (rx_take) begin
                idx <= idx + 1'b1;
                if (idx == IW'(BYTES - 1)) begin
                    word.valid    <= 1'b1;
                    word.data.raw <= {rx_data, shift};
                end else begin
                    shift <= {rx_data, shift[WB-9:8]};
                end
            end
        end
    end

    // a held word keeps its value and keeps the byte source stalled
    a_hold_word : assert property (@(posedge clk) disable iff (!rstn)
        word.valid && !word_ready |=> word.valid && $stable(word.data) && !rx_ready);

endmodule

`default_nettype wire

/* design/line_writer.sv */
`timescale 1ns/100ps
`default_nettype none
`include "loader_settings.svh"

module line_writer (
    input  logic                   clk,
    input  logic                   rstn,
    input  loader_pkg::fifo_push_t push,
    output logic                   push_ready,
    input  logic                   instr_end,
    output loader_pkg::line_wr_t   line,
    input  logic                   line_ready,
    output logic                   empty
);

    localparam int AW    = `LD_ADDR_BITS;
    localparam int WB    = `LD_WORD_BITS;
    localparam int LINE  = `LD_LINE_WORDS;
    localparam int DEPTH = `LD_FIFO_DEPTH;
    localparam int PW    = $clog2(DEPTH);
    localparam int CW    = PW + 1;
    localparam int NW    = $clog2(LINE) + 1;

    logic [WB-1:0] fifo_data [DEPTH];
    logic [AW-1:0] fifo_addr [DEPTH];

    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic [NW-1:0] line_n;    // words in the line on the port
    logic          flush;     // terminator seen, short line allowed

    logic                     do_push;
    logic                     do_pop;
    logic                     full_line;
    logic                     start;
    logic [CW-1:0]            n_avail;
    logic [LINE-1:0][WB-1:0]  next_data;

    assign push_ready = (count != CW'(DEPTH));
    assign empty      = (count == '0) && !line.valid;

    always_comb begin
        do_push   = push.valid && push_ready;
        do_pop    = line.valid && line_ready;
        full_line = (count >= CW'(LINE));
        n_avail   = full_line ? CW'(LINE) : count;
        start     = !line.valid && (full_line || (flush && count != '0));
    end

    // words past the count are padded with zero
    always_comb begin
        next_data = '0;
        for (int i = 0; i < LINE; i++) begin
            if (CW'(i) < n_avail) begin
                next_data[i] = fifo_data[rd_ptr + PW'(i)];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            fifo_data[wr_ptr] <= push.data;
            fifo_addr[wr_ptr] <= push.addr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            flush      <= 1'b0;
            line_n     <= '0;
            line.valid <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + PW'(line_n);   // ptr wraps at depth
            end
            count <= count + CW'(do_push) - (do_pop ? CW'(line_n) : '0);

            if (instr_end) begin
                flush <= 1'b1;
            end else if (start && !full_line) begin
                flush <= 1'b0;
            end

            if (start) begin
                line.valid <= 1'b1;
                line.addr  <= fifo_addr[rd_ptr] - AW'(`LD_BRAM_BYTES);
                line.data  <= next_data;
                line_n     <= NW'(n_avail);
            end else if (do_pop) begin
                line.valid <= 1'b0;
            end
        end
    end

    a_line_stable : assert property (@(posedge clk) disable iff (!rstn)
        line.valid && !line_ready |=>
            line.valid && $stable(line.addr) && $stable(line.data));

    a_count_bound : assert property (@(posedge clk) disable iff (!rstn)
        count <= CW'(DEPTH));

endmodule

`default_nettype wire

/* design/loader_pkg.sv */
`default_nettype none
`include "loader_settings.svh"

package loader_pkg;

    // one assembled word, seen raw or as an instruction
    typedef union packed {
        logic [`LD_WORD_BITS-1:0] raw;       // size header or data
        struct packed {
            logic [`LD_WORD_BITS-`LD_OPCODE_BITS-1:0] upper;
            logic [`LD_OPCODE_BITS-1:0]               opcode;  // zero ends the section
        } instr;
    } word_u;

    typedef struct packed {
        logic  valid;
        word_u data;
    } asm_word_t;

    typedef struct packed {
        logic                     en;
        logic                     sel;   // 1 instr memory, 0 data table
        logic [`LD_ADDR_BITS-1:0] addr;
        logic [`LD_WORD_BITS-1:0] data;
    } mem_wr_t;

    typedef struct packed {
        logic                     valid;
        logic [`LD_ADDR_BITS-1:0] addr;
        logic [`LD_WORD_BITS-1:0] data;
    } fifo_push_t;

    typedef struct packed {
        logic                                         valid;
        logic [`LD_ADDR_BITS-1:0]                     addr;
        logic [`LD_LINE_WORDS-1:0][`LD_WORD_BITS-1:0] data;  // [0] is lowest address
    } line_wr_t;

endpackage

`default_nettype wire

/* design/loader_settings.svh */
`ifndef LOADER_SETTINGS_SVH
`define LOADER_SETTINGS_SVH

// instruction memory size in words
`define LD_BRAM_WORDS 16
`define LD_BRAM_BYTES (`LD_BRAM_WORDS * 4)

// external memory line, lowest word first
`define LD_LINE_WORDS 4

// overflow queue, must be a power of two
`define LD_FIFO_DEPTH 8

`define LD_OPCODE_BITS 7
`define LD_WORD_BITS 32
`define LD_ADDR_BITS 32

`endif

/* design/program_loader.sv */
`timescale 1ns/100ps
`default_nettype none

module program_loader (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic [7:0]           rx_data,
    input  logic                 rx_valid,
    output logic                 rx_ready,
    output loader_pkg::mem_wr_t  mem_wr,
    output loader_pkg::line_wr_t line,
    input  logic                 line_ready,
    output logic                 load_done
);

    loader_pkg::asm_word_t  word;
    loader_pkg::fifo_push_t push;

    logic word_ready;
    logic push_ready;
    logic instr_end;
    logic data_done;
    logic empty;

    byte_assembler byte_assembler_i (
        .clk        (clk),
        .rstn       (rstn),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .rx_ready   (rx_ready),
        .word       (word),
        .word_ready (word_ready),
        .stop       (load_done)    // nothing more accepted once loaded
    );

    word_router word_router_i (
        .clk        (clk),
        .rstn       (rstn),
        .word       (word),
        .word_ready (word_ready),
        .push       (push),
        .push_ready (push_ready),
        .mem_wr     (mem_wr),
        .instr_end  (instr_end),
        .data_done  (data_done)
    );

    line_writer line_writer_i (
        .clk        (clk),
        .rstn       (rstn),
        .push       (push),
        .push_ready (push_ready),
        .instr_end  (instr_end),
        .line       (line),
        .line_ready (line_ready),
        .empty      (empty)
    );

    // sticky until reset
    always_ff @(posedge clk) begin
        if (!rstn) begin
            load_done <= 1'b0;
        end else if (data_done && empty) begin
            load_done <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* design/word_router.sv */
`timescale 1ns/100ps
`default_nettype none
`include "loader_settings.svh"

module word_router (
    input  logic                   clk,
    input  logic                   rstn,
    input  loader_pkg::asm_word_t  word,
    output logic                   word_ready,
    output loader_pkg::fifo_push_t push,
    input  logic                   push_ready,
    output loader_pkg::mem_wr_t    mem_wr,
    output logic                   instr_end,
    output logic                   data_done
);

    localparam int AW = `LD_ADDR_BITS;
    localparam int WB = `LD_WORD_BITS;

    localparam logic [1:0] PH_SIZE  = 2'd0;
    localparam logic [1:0] PH_INSTR = 2'd1;
    localparam logic [1:0] PH_DATA  = 2'd2;

    logic [1:0]    phase;
    logic [AW-1:0] addr;       // byte address of the next word
    logic [AW-1:0] end_addr;   // terminator address, base of data table
    logic [WB-1:0] remain;     // bytes still expected after the header

    logic is_term;
    logic to_fifo;
    logic take;
    logic last;

    always_comb begin
        is_term = (phase == PH_INSTR) && (word.data.instr.opcode == '0);
        to_fifo = (phase == PH_INSTR) && !is_term && (addr >= AW'(`LD_BRAM_BYTES));
        // overflow words wait for room in the queue
        word_ready = !data_done && (!to_fifo || push_ready);
        take = word.valid && word_ready;
        last = (phase != PH_SIZE) && (remain <= WB'(4));
    end

    // push in the acceptance cycle
    always_comb begin
        push.valid = take && to_fifo;
        push.addr  = addr;
        push.data  = word.data.raw;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            phase     <= PH_SIZE;
            addr      <= '0;
            end_addr  <= '0;
            remain    <= '0;
            mem_wr.en <= 1'b0;
            instr_end <= 1'b0;
            data_done <= 1'b0;
        end else begin
            mem_wr.en <= 1'b0;
            instr_end <= 1'b0;
            if (take) begin
                case (phase)
                    PH_SIZE: begin
                        remain <= word.data.raw;   // byte count after header
                        phase  <= PH_INSTR;
                    end
                    PH_INSTR: begin
                        remain <= remain - WB'(4);
                        if (is_term) begin
                            // terminator is not stored anywhere
                            end_addr  <= addr;
                            instr_end <= 1'b1;
                            phase     <= PH_DATA;
                        end else begin
                            addr <= addr + AW'(4);
                            if (!to_fifo) begin
                                mem_wr.en   <= 1'b1;
                                mem_wr.sel  <= 1'b1;
                                mem_wr.addr <= addr;
                                mem_wr.data <= word.data.raw;
                            end
                        end
                    end
                    default: begin
                        remain      <= remain - WB'(4);
                        addr        <= addr + AW'(4);
                        mem_wr.en   <= 1'b1;
                        mem_wr.sel  <= 1'b0;
                        mem_wr.addr <= addr - end_addr;  // table starts at zero
                        mem_wr.data <= word.data.raw;
                    end
                endcase
                if (last) begin
                    data_done <= 1'b1;
                end
            end
        end
    end

    // queue space comes from the line writer
    a_push_room : assert property (@(posedge clk) disable iff (!rstn)
        push.valid |-> push_ready);

endmodule

`default_nettype wire

/* dv/program_loader_tb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "loader_settings.svh"

module program_loader_tb;

    localparam int BRAM_WORDS   = `LD_BRAM_WORDS;
    localparam int BRAM_BYTES   = `LD_BRAM_BYTES;
    localparam int LINE         = `LD_LINE_WORDS;
    localparam int MAX_LINES    = 16;
    localparam int MAX_D        = 16;
    localparam int NUM_CASES    = 5;
    localparam int STALL_WINDOW = 64;   // line_ready decision held this long
    localparam int POST_CYCLES  = 16;

    typedef struct packed {
        int   n;       // instruction count
        int   d;       // data word count
        int   stall;   // line_ready stall percent
        int   drop;    // rx_valid drop percent
        int   lines;   // expected external lines
        logic bp;      // rx_ready must stay low for a while
    } case_t;

    localparam case_t CASES [NUM_CASES] = '{
        '{5,  3, 0,  20, 0,  1'b0},
        '{16, 2, 20, 20, 0,  1'b0},
        '{22, 4, 30, 20, 2,  1'b0},   // short last line
        '{80, 5, 70, 0,  16, 1'b1},
        '{35, 1, 0,  20, 5,  1'b0}
    };

    logic                 clk;
    logic                 rstn;
    logic [7:0]           rx_data;
    logic                 rx_valid;
    logic                 rx_ready;
    loader_pkg::mem_wr_t  mem_wr;
    loader_pkg::line_wr_t line;
    logic                 line_ready;
    logic                 load_done;

    logic [31:0] seed;
    int          value_errors;
    int          other_errors;
    int          cycles;
    int          limit;
    int          mem_writes;
    int          lines_seen;
    logic [7:0]  bytes [$];

    logic [31:0] exp_imem [BRAM_WORDS];
    logic [31:0] got_imem [BRAM_WORDS];
    int          imem_hits [BRAM_WORDS];
    logic [31:0] exp_dtab [MAX_D];
    logic [31:0] got_dtab [MAX_D];
    int          dtab_hits [MAX_D];
    logic [31:0] exp_ext [MAX_LINES*LINE];
    logic [31:0] got_ext [MAX_LINES*LINE];
    int          line_hits [MAX_LINES];

    program_loader program_loader_i (
        .clk        (clk),
        .rstn       (rstn),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .rx_ready   (rx_ready),
        .mem_wr     (mem_wr),
        .line       (line),
        .line_ready (line_ready),
        .load_done  (load_done)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic roll(input int pct, output logic hit);
        seed = lcg_step(seed);
        hit  = int'((seed >> 8) % 32'd100) < pct;
    endtask

    task automatic tick();
        @(negedge clk);
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, loader never finished", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    endtask

    task automatic push_word(input logic [31:0] w);
        for (int b = 0; b < 4; b++) begin
            bytes.push_back(w[8*b +: 8]);   // little endian
        end
    endtask

    task automatic build_program(input case_t c);
        logic [31:0] w;
        bytes.delete();
        for (int i = 0; i < BRAM_WORDS; i++) begin
            exp_imem[i]  = '0;
            imem_hits[i] = 0;
        end
        for (int i = 0; i < MAX_D; i++) begin
            exp_dtab[i]  = '0;
            dtab_hits[i] = 0;
        end
        for (int i = 0; i < MAX_LINES*LINE; i++) begin
            exp_ext[i] = '0;   // padding of the last line
        end
        for (int i = 0; i < MAX_LINES; i++) begin
            line_hits[i] = 0;
        end
        push_word(32'(4 * (c.n + 1 + c.d)));
        for (int k = 0; k < c.n; k++) begin
            seed = lcg_step(seed);
            w    = seed;
            if (w[`LD_OPCODE_BITS-1:0] == '0) begin
                w[0] = 1'b1;
            end
            push_word(w);
            if (k < BRAM_WORDS) exp_imem[k] = w;
            else exp_ext[k - BRAM_WORDS] = w;
        end
        seed = lcg_step(seed);
        w    = seed;
        w[`LD_OPCODE_BITS-1:0] = '0;   // terminator
        push_word(w);
        for (int j = 0; j < c.d; j++) begin
            seed = lcg_step(seed);
            exp_dtab[j] = seed;
            push_word(seed);
        end
    endtask

    // sampled at the falling edge ahead of the rising edge that commits it
    task automatic record_writes(input case_t c, input logic done);
        int idx;
        if (mem_wr.en) begin
            idx = int'(mem_wr.addr >> 2);
            mem_writes++;
            if (done) begin
                $display("memory write after load_done at address %h", mem_wr.addr);
                other_errors++;
            end
            if (mem_wr.addr[1:0] != 2'b00) begin
                $display("misaligned memory write address %h", mem_wr.addr);
                other_errors++;
            end else if (mem_wr.sel && mem_wr.addr < 32'(BRAM_BYTES)) begin
                got_imem[idx] = mem_wr.data;
                imem_hits[idx]++;
            end else if (!mem_wr.sel && mem_wr.addr < 32'(4 * c.d)) begin
                got_dtab[idx] = mem_wr.data;
                dtab_hits[idx]++;
            end else begin
                $display("memory write out of range, sel %0d address %h", mem_wr.sel, mem_wr.addr);
                other_errors++;
            end
        end
        if (line.valid && line_ready) begin
            idx = int'(line.addr / 32'(4 * LINE));
            lines_seen++;
            if (done) begin
                $display("line written after load_done at address %h", line.addr);
                other_errors++;
            end
            if (line.addr % 32'(4 * LINE) != 0 || idx >= c.lines) begin
                $display("line address %h is not an expected line", line.addr);
                other_errors++;
            end else begin
                line_hits[idx]++;
                for (int w = 0; w < LINE; w++) begin
                    got_ext[idx*LINE + w] = line.data[w];
                end
            end
        end
    endtask

    task automatic check_results(input case_t c, input int max_low);
        for (int k = 0; k < BRAM_WORDS; k++) begin
            if (imem_hits[k] != ((k < c.n) ? 1 : 0)) begin
                $display("instruction word %0d written %0d times", k, imem_hits[k]);
                other_errors++;
            end else if (k < c.n && got_imem[k] != exp_imem[k]) begin
                $display("Fail mem_wr.data at imem[%0d]: got %h, expected %h",
                         k, got_imem[k], exp_imem[k]);
                value_errors++;
            end
        end
        for (int j = 0; j < MAX_D; j++) begin
            if (dtab_hits[j] != ((j < c.d) ? 1 : 0)) begin
                $display("data word %0d written %0d times", j, dtab_hits[j]);
                other_errors++;
            end else if (j < c.d && got_dtab[j] != exp_dtab[j]) begin
                $display("Fail mem_wr.data at dtab[%0d]: got %h, expected %h",
                         j, got_dtab[j], exp_dtab[j]);
                value_errors++;
            end
        end
        for (int m = 0; m < MAX_LINES; m++) begin
            if (line_hits[m] != ((m < c.lines) ? 1 : 0)) begin
                $display("line %0d written %0d times", m, line_hits[m]);
                other_errors++;
            end else if (m < c.lines) begin
                for (int w = 0; w < LINE; w++) begin
                    if (got_ext[m*LINE + w] != exp_ext[m*LINE + w]) begin
                        $display("Fail line.data[%0d] of line %0d: got %h, expected %h",
                                 w, m, got_ext[m*LINE + w], exp_ext[m*LINE + w]);
                        value_errors++;
                    end
                end
            end
        end
        if (c.bp && max_low <= 4) begin
            $display("rx_ready was never held low by line back-pressure");
            other_errors++;
        end
    endtask

    task automatic run_case(input case_t c, input int ci);
        int   pos;
        int   post;
        int   low_run;
        int   max_low;
        int   stall_left;
        int   exp_mem;
        logic stalled;
        logic drop;
        logic done_seen;
        rstn       = 1'b0;
        rx_valid   = 1'b0;
        line_ready = 1'b0;
        build_program(c);
        repeat (8) tick();
        if (!rx_ready || line.valid || mem_wr.en || load_done) begin
            $display("case %0d: outputs not at their reset values", ci);
            other_errors++;
        end
        rstn       = 1'b1;
        pos        = 0;
        post       = 0;
        low_run    = 0;
        max_low    = 0;
        stall_left = 0;
        stalled    = 1'b0;
        done_seen  = 1'b0;
        mem_writes = 0;
        lines_seen = 0;
        exp_mem    = ((c.n < BRAM_WORDS) ? c.n : BRAM_WORDS) + c.d;
        while (post < POST_CYCLES) begin
            tick();
            if (stall_left == 0) begin
                roll(c.stall, stalled);
                stall_left = STALL_WINDOW;
            end
            stall_left--;
            line_ready = !stalled;
            if (done_seen) begin
                seed     = lcg_step(seed);
                rx_valid = 1'b1;         // extra bytes must be refused
                rx_data  = seed[7:0];
                post++;
                if (rx_ready) begin
                    $display("case %0d: rx_ready high after load_done", ci);
                    other_errors++;
                end
            end else if (pos < bytes.size()) begin
                roll(c.drop, drop);
                rx_valid = !drop;
                rx_data  = bytes[pos];
                if (rx_valid && rx_ready) pos++;
            end else begin
                rx_valid = 1'b0;
            end
            if (!rx_ready && !load_done) begin
                low_run++;
                if (low_run > max_low) max_low = low_run;
            end else begin
                low_run = 0;
            end
            record_writes(c, done_seen || load_done);
            if (load_done && !done_seen) begin
                done_seen = 1'b1;
                if (pos != bytes.size() || mem_writes != exp_mem || lines_seen != c.lines) begin
                    $display("case %0d: load_done rose before every word landed", ci);
                    other_errors++;
                end
            end else if (!load_done && done_seen) begin
                $display("case %0d: load_done dropped before reset", ci);
                other_errors++;
            end
        end
        rx_valid = 1'b0;
        check_results(c, max_low);
    endtask

    initial begin
        int total_bytes;
        clk          = 1'b0;
        rstn         = 1'b0;
        rx_data      = '0;
        rx_valid     = 1'b0;
        line_ready   = 1'b0;
        seed         = 32'h4d879da8;
        value_errors = 0;
        other_errors = 0;
        cycles       = 0;
        total_bytes  = 0;
        for (int i = 0; i < NUM_CASES; i++) begin
            total_bytes += 4 * (CASES[i].n + CASES[i].d + 2);
        end
        limit = 40 * total_bytes + 200;
        for (int i = 0; i < NUM_CASES; i++) begin
            run_case(CASES[i], i);
        end
        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# builds and runs the program loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal \
    --top-module program_loader_tb \
    -f compile.f \
    --Mdir obj_dir \
    -o program_loader_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/program_loader_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
echo "pass message not found"
exit 1
